//--- decode_issue_unit.sv
// ------------------------------------------------
// One-entry decode register fed by valid/ready.
// Issue is combinational from that register and
// stalls on any pending source or destination.
// ------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module decode_issue_unit import tinyrv1_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          fetch_val,
  output logic          fetch_rdy,
  input  fetch_msg_t    fetch_msg,
  output logic          issue_val,
  output issue_msg_t    issue_msg,
  input  logic          complete_val,
  input  complete_msg_t complete_msg
);

  // Decode register
  logic       dec_val;
  fetch_msg_t dec_msg;

  logic fetch_xfer;
  logic issue_fire;
  logic stall;

  // Decoder outputs
  uop_e      dec_uop;
  reg_addr_t dec_raddr0;
  reg_addr_t dec_raddr1;
  reg_addr_t dec_waddr;
  logic      dec_wen;
  logic      dec_op2_sel;
  logic      dec_uses_rs2;
  word_t     dec_imm;

  // Register file outputs
  word_t rdata0;
  word_t rdata1;
  logic  pending0;
  logic  pending1;
  logic  pending2;

  // ------------------------------------------------
  // Fetch side
  // ------------------------------------------------

  assign fetch_xfer = fetch_val && fetch_rdy;

  // Accept when empty or when the held word leaves now
  assign fetch_rdy = !dec_val || issue_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_val <= 1'b0;
    end else if (fetch_xfer) begin
      dec_val <= 1'b1;
    end else if (issue_fire) begin
      dec_val <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      dec_msg <= fetch_msg;
    end
  end

  // ------------------------------------------------
  // Decode and operand read
  // ------------------------------------------------

  inst_decoder decoder_i (
    .inst     (dec_msg.inst),
    .uop      (dec_uop),
    .raddr0   (dec_raddr0),
    .raddr1   (dec_raddr1),
    .waddr    (dec_waddr),
    .wen      (dec_wen),
    .op2_sel  (dec_op2_sel),
    .uses_rs2 (dec_uses_rs2),
    .imm      (dec_imm)
  );

  regfile_scoreboard regfile_i (
    .clk        (clk),
    .rst        (rst),
    .raddr0     (dec_raddr0),
    .raddr1     (dec_raddr1),
    .rdata0     (rdata0),
    .rdata1     (rdata1),
    .waddr      (complete_msg.waddr),
    .wdata      (complete_msg.wdata),
    .wen        (complete_val && complete_msg.wen),
    .set_addr   (dec_waddr),
    .set_en     (issue_fire && dec_wen),
    .pend_addr0 (dec_raddr0),
    .pend_addr1 (dec_raddr1),
    .pend_addr2 (dec_waddr),
    .pending0   (pending0),
    .pending1   (pending1),
    .pending2   (pending2)
  );

  // ------------------------------------------------
  // Hazard check and issue
  // ------------------------------------------------

  // rs1 needs no gate, unused rs1 decodes to x0
  // rd is checked too so WAW cannot clear early
  assign stall = pending0 || (pending1 && dec_uses_rs2) ||
                 (pending2 && dec_wen);

  assign issue_fire = dec_val && !stall;
  assign issue_val  = issue_fire;

  always_comb begin
    issue_msg.pc    = dec_msg.pc;
    issue_msg.uop   = dec_uop;
    issue_msg.waddr = dec_waddr;
    issue_msg.wen   = dec_wen;
    issue_msg.op1   = rdata0;
    // Immediate for addi, rs2 otherwise
    issue_msg.op2   = dec_op2_sel ? dec_imm : rdata1;
  end

endmodule

`default_nettype wire

//--- exec_pipe.sv
// ------------------------------------------------
// Fixed two-stage execute pipe, no back-pressure.
// add, addi and mul share one latency so results
// leave in issue order.
// ------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module exec_pipe import tinyrv1_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          issue_val,
  input  issue_msg_t    issue_msg,
  output logic          exec_val,
  output complete_msg_t exec_msg
);

  // One valid bit per stage, oldest at the top
  logic [exec_latency-1:0] val_q;

  // Stage one operands
  issue_msg_t s1_q;

  // Stage two result
  complete_msg_t s2_q;

  word_t sum;
  word_t prod;
  logic  s1_illegal;

  // ------------------------------------------------
  // Valid shift chain
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= '0;
    end else begin
      val_q <= {val_q[exec_latency-2:0], issue_val};
    end
  end

  // ------------------------------------------------
  // Stage one
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (issue_val) begin
      s1_q <= issue_msg;
    end
  end

  // ------------------------------------------------
  // Stage two
  // ------------------------------------------------

  // addi already has the immediate in op2
  assign sum  = s1_q.op1 + s1_q.op2;
  // Low 32 bits of the product
  assign prod = s1_q.op1 * s1_q.op2;

  assign s1_illegal = (s1_q.uop == uop_illegal);

  always_ff @(posedge clk) begin
    if (val_q[0]) begin
      s2_q.pc      <= s1_q.pc;
      s2_q.waddr   <= s1_q.waddr;
      s2_q.wdata   <= (s1_q.uop == uop_mul) ? prod : sum;
      // Illegal words never write
      s2_q.wen     <= s1_q.wen && !s1_illegal;
      s2_q.illegal <= s1_illegal;
    end
  end

  assign exec_val = val_q[exec_latency-1];
  assign exec_msg = s2_q;

endmodule

`default_nettype wire

//--- inst_decoder.sv
// ------------------------------------------------
// Purely combinational decoder. Illegal words come
// out with wen low and all register fields zero,
// so they never wait on the scoreboard.
// ------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module inst_decoder import tinyrv1_pkg::*; (
  input  word_t     inst,
  output uop_e      uop,
  output reg_addr_t raddr0,
  output reg_addr_t raddr1,
  output reg_addr_t waddr,
  output logic      wen,
  output logic      op2_sel,
  output logic      uses_rs2,
  output word_t     imm
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Per-instruction matches
  logic is_add;
  logic is_mul;
  logic is_addi;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // R-type needs opcode, funct3 and funct7 all exact
  assign is_add  = (opcode == opcode_op) && (funct3 == funct3_add) &&
                   (funct7 == funct7_add);
  assign is_mul  = (opcode == opcode_op) && (funct3 == funct3_add) &&
                   (funct7 == funct7_mul);
  // I-type has no funct7, upper bits are immediate
  assign is_addi = (opcode == opcode_op_imm) && (funct3 == funct3_add);

  always_comb begin
    // Defaults describe an illegal word
    uop      = uop_illegal;
    raddr0   = '0;
    raddr1   = '0;
    waddr    = '0;
    wen      = 1'b0;
    op2_sel  = 1'b0;
    uses_rs2 = 1'b0;

    if (is_add || is_mul) begin
      uop      = is_mul ? uop_mul : uop_add;
      raddr0   = inst[19:15];
      raddr1   = inst[24:20];
      waddr    = inst[11:7];
      wen      = 1'b1;
      uses_rs2 = 1'b1;
    end else if (is_addi) begin
      uop      = uop_addi;
      raddr0   = inst[19:15];
      waddr    = inst[11:7];
      wen      = 1'b1;
      // Second operand from the immediate
      op2_sel  = 1'b1;
    end
  end

  // Sign-extended I-type immediate
  assign imm = {{20{inst[31]}}, inst[31:20]};

endmodule

`default_nettype wire

//--- regfile_scoreboard.sv
// ------------------------------------------------
// 31 writable registers plus per-register pending
// bits. Reads are combinational with no bypass, so
// a write is visible the cycle after its edge.
// ------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module regfile_scoreboard import tinyrv1_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t raddr0,
  input  reg_addr_t raddr1,
  output word_t     rdata0,
  output word_t     rdata1,
  input  reg_addr_t waddr,
  input  word_t     wdata,
  input  logic      wen,
  input  reg_addr_t set_addr,
  input  logic      set_en,
  input  reg_addr_t pend_addr0,
  input  reg_addr_t pend_addr1,
  input  reg_addr_t pend_addr2,
  output logic      pending0,
  output logic      pending1,
  output logic      pending2
);

  // No storage for x0
  word_t regs [1:num_regs-1];

  // Bit 0 stays clear forever
  logic [num_regs-1:0] pend_q;

  // ------------------------------------------------
  // Register storage
  // ------------------------------------------------

  // All registers read zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // ------------------------------------------------
  // Pending bits
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q <= '0;
    end else begin
      // Clear on writeback
      if (wen && (waddr != '0)) begin
        pend_q[waddr] <= 1'b0;
      end
      // New issue to the same register wins
      if (set_en && (set_addr != '0)) begin
        pend_q[set_addr] <= 1'b1;
      end
    end
  end

  assign pending0 = pend_q[pend_addr0];
  assign pending1 = pend_q[pend_addr1];
  assign pending2 = pend_q[pend_addr2];

endmodule

`default_nettype wire

//--- result_unit.sv
// ------------------------------------------------
// Writeback register. Always accepts; its output is
// both the register-file write and the completion.
// ------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module result_unit import tinyrv1_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          exec_val,
  input  complete_msg_t exec_msg,
  output logic          complete_val,
  output complete_msg_t complete_msg
);

  logic          val_q;
  complete_msg_t msg_q;

  // Valid for exactly one cycle per result
  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else begin
      val_q <= exec_val;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (exec_val) begin
      msg_q <= exec_msg;
    end
  end

  assign complete_val = val_q;
  assign complete_msg = msg_q;

endmodule

`default_nettype wire

//--- tb_tinyrv1_issue.sv
// ------------------------------------------------
// Random and directed programs against an in-order
// register model. Fixed seed; inputs change on the
// falling edge, outputs are sampled there too.
// ------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module tb_tinyrv1_issue import tinyrv1_pkg::*; ();

  // Instruction kinds for the generator
  localparam int k_add  = 0;
  localparam int k_addi = 1;
  localparam int k_mul  = 2;
  localparam int k_ill  = 3;

  localparam int fetch_timeout = 50;
  localparam int drain_timeout = 100;

  logic          clk;
  logic          rst;
  logic          fetch_val;
  logic          fetch_rdy;
  fetch_msg_t    fetch_msg;
  logic          complete_val;
  complete_msg_t complete_msg;

  // Architectural model and expected completions
  word_t         model_regs [num_regs];
  complete_msg_t exp_q [$];

  integer seed;
  word_t  pc;
  string  test_name;
  int     checks;
  int     errors;
  int     tests;
  int     c0;
  int     e0;
  int     last_wait;
  int     transfers;

  tinyrv1_issue_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .fetch_val    (fetch_val),
    .fetch_rdy    (fetch_rdy),
    .fetch_msg    (fetch_msg),
    .complete_val (complete_val),
    .complete_msg (complete_msg)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------
  // Encoding and model
  // ------------------------------------------------

  function automatic word_t encode(int kind, int rd, int rs1, int rs2, int imm, word_t ill);
    case (kind)
      k_add:  encode = {funct7_add, rs2[4:0], rs1[4:0], funct3_add, rd[4:0], opcode_op};
      k_mul:  encode = {funct7_mul, rs2[4:0], rs1[4:0], funct3_add, rd[4:0], opcode_op};
      k_addi: encode = {imm[11:0], rs1[4:0], funct3_add, rd[4:0], opcode_op_imm};
      default: begin
        // Either a sub or a branch opcode, neither is supported
        if (ill[31]) begin
          encode = {7'b0100000, ill[24:15], funct3_add, ill[11:7], opcode_op};
        end else begin
          encode = {ill[31:7], 7'b1100011};
        end
      end
    endcase
  endfunction

  function automatic int pick(int n);
    pick = $unsigned($random(seed)) % n;
  endfunction

  // Executes one accepted instruction in program order
  task automatic accept_model(int kind, int rd, int rs1, int rs2, int imm);
    complete_msg_t e;
    word_t         v;
    e    = '0;
    e.pc = pc;
    case (kind)
      k_add:   v = model_regs[rs1] + model_regs[rs2];
      k_addi:  v = model_regs[rs1] + word_t'(imm);
      k_mul:   v = model_regs[rs1] * model_regs[rs2];
      default: v = '0;
    endcase
    if (kind == k_ill) begin
      e.illegal = 1'b1;
    end else begin
      e.waddr = rd[4:0];
      e.wdata = v;
      // x0 still reports wen
      e.wen   = 1'b1;
      if (rd != 0) begin
        model_regs[rd] = v;
      end
    end
    exp_q.push_back(e);
  endtask

  // ------------------------------------------------
  // Stimulus helpers, all entered on a falling edge
  // ------------------------------------------------

  task automatic send(int kind, int rd, int rs1, int rs2, int imm);
    int    waited;
    word_t ill;
    waited         = 0;
    ill            = $random(seed);
    fetch_val      = 1'b1;
    fetch_msg.inst = encode(kind, rd, rs1, rs2, imm, ill);
    fetch_msg.pc   = pc;
    #1;
    while (!fetch_rdy && waited < fetch_timeout) begin
      @(negedge clk);
      #1;
      waited++;
    end
    last_wait = waited;
    if (!fetch_rdy) begin
      $display("timeout: fetch_rdy stayed low in %s", test_name);
      errors++;
      fetch_val = 1'b0;
    end else begin
      // Transfer lands on the coming rising edge
      accept_model(kind, rd, rs1, rs2, imm);
      pc += 4;
    end
    @(negedge clk);
  endtask

  task automatic send_random(int base, int n);
    int r;
    int kind;
    r    = pick(10);
    kind = (r < 3) ? k_add : (r < 6) ? k_addi : (r < 9) ? k_mul : k_ill;
    send(kind, base + pick(n), base + pick(n), base + pick(n), $random(seed) % 2048);
  endtask

  task automatic idle(int n);
    fetch_val = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic drain();
    int waited;
    waited    = 0;
    fetch_val = 1'b0;
    while (exp_q.size() != 0 && waited < drain_timeout) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d completions never arrived in %s", exp_q.size(), test_name);
      errors++;
      exp_q.delete();
    end
    @(negedge clk);
  endtask

  task automatic start_test(string name);
    test_name = name;
    c0        = checks;
    e0        = errors;
  endtask

  task automatic end_test();
    drain();
    tests++;
    $display("%s: %0d checks, %0d errors", test_name, checks - c0, errors - e0);
  endtask

  // ------------------------------------------------
  // Completion checker
  // ------------------------------------------------

  always @(negedge clk) begin : check_completion
    complete_msg_t e;
    if (!rst && complete_val) begin
      if (exp_q.size() == 0) begin
        $display("completion with pc %h arrived with none expected in %s",
                 complete_msg.pc, test_name);
        errors++;
      end else begin
        e = exp_q.pop_front();
        checks++;
        // pc order also proves completions follow fetch order
        assert (complete_msg.pc == e.pc) else begin
          $display("error: %s pc expected %h actual %h", test_name, e.pc, complete_msg.pc);
          errors++;
        end
        assert (complete_msg.illegal == e.illegal && complete_msg.wen == e.wen) else begin
          $display("error: %s illegal/wen expected %b%b actual %b%b", test_name,
                   e.illegal, e.wen, complete_msg.illegal, complete_msg.wen);
          errors++;
        end
        if (!e.illegal) begin
          assert (complete_msg.waddr == e.waddr && complete_msg.wdata == e.wdata) else begin
            $display("error: %s pc %h x%0d=%h expected x%0d=%h actual", test_name, e.pc,
                     e.waddr, e.wdata, complete_msg.waddr, complete_msg.wdata);
            errors++;
          end
        end
      end
    end
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------

  initial begin
    rst       = 1'b1;
    fetch_val = 1'b0;
    fetch_msg = '0;
    seed      = 76;
    pc        = '0;
    checks    = 0;
    errors    = 0;
    tests     = 0;
    last_wait = 0;
    for (int i = 0; i < num_regs; i++) begin
      model_regs[i] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Idle outputs, then read every register before writing it
    start_test("reset_state");
    repeat (4) begin
      #1;
      checks++;
      assert (!complete_val && fetch_rdy) else begin
        $display("error: %s complete_val/fetch_rdy expected 01 actual %b%b", test_name,
                 complete_val, fetch_rdy);
        errors++;
      end
      @(negedge clk);
    end
    for (int r = 1; r < num_regs; r++) begin
      send(k_add, r, r, r, 0);
    end
    end_test();

    // Small pool x0..x4 forces hazards, random idles between transfers
    start_test("random_program");
    for (int i = 0; i < 200; i++) begin
      if (pick(3) == 0) begin
        idle(1 + pick(2));
      end
      send_random(0, 5);
    end
    end_test();

    // Back-to-back RAW and WAW on x5 and x6
    start_test("dependency_chains");
    send(k_addi, 5, 0, 0, 3);
    send(k_addi, 5, 5, 0, 7);
    send(k_mul, 5, 5, 5, 0);
    send(k_add, 6, 5, 5, 0);
    send(k_addi, 6, 6, 0, -1);
    send(k_mul, 5, 6, 5, 0);
    send(k_addi, 5, 0, 0, 1);
    for (int i = 0; i < 40; i++) begin
      send_random(5, 2);
    end
    end_test();

    start_test("x0_writes");
    send(k_addi, 0, 0, 0, 100);
    send(k_add, 7, 0, 0, 0);
    send(k_addi, 7, 0, 0, 5);
    send(k_mul, 0, 7, 7, 0);
    send(k_add, 8, 0, 7, 0);
    end_test();

    // Later results show that no register changed
    start_test("illegal_words");
    send(k_addi, 9, 0, 0, 11);
    send(k_ill, 0, 0, 0, 0);
    send(k_add, 10, 9, 9, 0);
    repeat (5) send(k_ill, 0, 0, 0, 0);
    send(k_addi, 10, 10, 0, 0);
    send(k_mul, 11, 9, 10, 0);
    end_test();

    // Independent ops with fetch_val held high
    start_test("throughput");
    transfers = 0;
    for (int i = 0; i < 8; i++) begin
      send(k_addi, 16 + i, 0, 0, i + 1);
      if (last_wait == 0) begin
        transfers++;
      end
    end
    checks++;
    assert (transfers == 8) else begin
      $display("error: %s transfers in 8 cycles expected %0d actual %0d",
               test_name, 8, transfers);
      errors++;
    end
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tinyrv1_issue_assertions.sv
// ------------------------------------------------
// Handshake and scoreboard rules, bound into every
// decode_issue_unit. Keeps its own record of the
// destinations issued and not yet written back.
// ------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module tinyrv1_issue_assertions import tinyrv1_pkg::*; (
  input logic          clk,
  input logic          rst,
  input logic          fetch_val,
  input logic          fetch_rdy,
  input fetch_msg_t    fetch_msg,
  input logic          issue_val,
  input issue_msg_t    issue_msg,
  input logic          complete_val,
  input complete_msg_t complete_msg,
  input reg_addr_t     dec_raddr0,
  input reg_addr_t     dec_raddr1,
  input logic          dec_uses_rs2
);

  // Destinations seen on issue, dropped on writeback
  logic [num_regs-1:0] in_flight;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      if (complete_val && complete_msg.wen) begin
        in_flight[complete_msg.waddr] <= 1'b0;
      end
      // x0 never waits
      if (issue_val && issue_msg.wen && (issue_msg.waddr != '0)) begin
        in_flight[issue_msg.waddr] <= 1'b1;
      end
    end
  end

  // No issue over an in-flight source or destination
  no_issue_on_pending: assert property (@(posedge clk) disable iff (rst)
    issue_val |-> (!in_flight[dec_raddr0] &&
                   !(dec_uses_rs2 && in_flight[dec_raddr1]) &&
                   !(issue_msg.wen && in_flight[issue_msg.waddr])))
    else $error("issue while a needed register is pending");

  // Source holds valid and payload until accepted
  fetch_hold: assert property (@(posedge clk) disable iff (rst)
    (fetch_val && !fetch_rdy) |=> (fetch_val && $stable(fetch_msg)))
    else $error("fetch message changed before transfer");

  // Writeback quiet right after reset
  reset_quiet: assert property (@(posedge clk) rst |=> !complete_val)
    else $error("complete_val high in the cycle after reset");

endmodule

bind decode_issue_unit tinyrv1_issue_assertions assertions_i (
  .clk          (clk),
  .rst          (rst),
  .fetch_val    (fetch_val),
  .fetch_rdy    (fetch_rdy),
  .fetch_msg    (fetch_msg),
  .issue_val    (issue_val),
  .issue_msg    (issue_msg),
  .complete_val (complete_val),
  .complete_msg (complete_msg),
  .dec_raddr0   (dec_raddr0),
  .dec_raddr1   (dec_raddr1),
  .dec_uses_rs2 (dec_uses_rs2)
);

`default_nettype wire

//--- tinyrv1_issue_top.f
tinyrv1_pkg.sv
inst_decoder.sv
regfile_scoreboard.sv
decode_issue_unit.sv
exec_pipe.sv
result_unit.sv
tinyrv1_issue_top.sv
tinyrv1_issue_assertions.sv
tb_tinyrv1_issue.sv

//--- tinyrv1_issue_top.sv
// ------------------------------------------------
// Decode-issue, execute and writeback in a row.
// Issue to completion takes three edges.
// ------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module tinyrv1_issue_top import tinyrv1_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          fetch_val,
  output logic          fetch_rdy,
  input  fetch_msg_t    fetch_msg,
  output logic          complete_val,
  output complete_msg_t complete_msg
);

  logic          issue_val;
  issue_msg_t    issue_msg;
  logic          exec_val;
  complete_msg_t exec_msg;

  // Completion also loops back for writeback
  decode_issue_unit decode_issue_i (
    .clk          (clk),
    .rst          (rst),
    .fetch_val    (fetch_val),
    .fetch_rdy    (fetch_rdy),
    .fetch_msg    (fetch_msg),
    .issue_val    (issue_val),
    .issue_msg    (issue_msg),
    .complete_val (complete_val),
    .complete_msg (complete_msg)
  );

  exec_pipe exec_i (
    .clk       (clk),
    .rst       (rst),
    .issue_val (issue_val),
    .issue_msg (issue_msg),
    .exec_val  (exec_val),
    .exec_msg  (exec_msg)
  );

  result_unit result_i (
    .clk          (clk),
    .rst          (rst),
    .exec_val     (exec_val),
    .exec_msg     (exec_msg),
    .complete_val (complete_val),
    .complete_msg (complete_msg)
  );

endmodule

`default_nettype wire

//--- tinyrv1_pkg.sv
// ------------------------------------------------
// Shared types and constants for the decode-issue
// core. Only add, addi and mul are legal; every
// other instruction word decodes as illegal.
// ------------------------------------------------
`default_nettype none

package tinyrv1_pkg;

  // ------------------------------------------------
  // Basic widths
  // ------------------------------------------------

  // Data, instruction and PC words
  typedef logic [31:0] word_t;

  // Architectural register index
  typedef logic [4:0] reg_addr_t;

  // Micro-ops seen by the execute pipe
  typedef enum logic [1:0] {
    uop_add,
    uop_addi,
    uop_mul,
    uop_illegal
  } uop_e;

  // ------------------------------------------------
  // Encoding fields (RV32I / RV32M)
  // ------------------------------------------------

  // Register-register ops (add, mul)
  localparam logic [6:0] opcode_op     = 7'b0110011;
  // Register-immediate ops (addi)
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  localparam logic [6:0] funct7_add    = 7'b0000000;
  localparam logic [6:0] funct7_mul    = 7'b0000001;

  // Shared by add, addi and mul
  localparam logic [2:0] funct3_add    = 3'b000;

  // Architectural register count, x0 included
  localparam int num_regs     = 32;

  // Edges from issue to the execute output
  localparam int exec_latency = 2;

  // ------------------------------------------------
  // Stage messages
  // ------------------------------------------------

  typedef struct packed {
    word_t inst;
    word_t pc;
  } fetch_msg_t;

  typedef struct packed {
    word_t     pc;
    uop_e      uop;
    reg_addr_t waddr;
    logic      wen;
    word_t     op1;
    word_t     op2;
  } issue_msg_t;

  typedef struct packed {
    word_t     pc;
    reg_addr_t waddr;
    word_t     wdata;
    logic      wen;
    logic      illegal;
  } complete_msg_t;

endpackage

`default_nettype wire
